// File: vlog.f
+incdir+rtl
rtl/board_pkg.sv
rtl/reset_ctrl.sv
rtl/timebase.sv
rtl/fan_pwm.sv
rtl/board_ctrl_top.sv
testbench/tb_board_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the board housekeeping testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f \
  --top-module tb_board_ctrl \
  -o sim_tb

./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -q "Something failed" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
  echo "Simulation ended without a result, see $LOG"
  exit 1
fi
echo "Simulation passed"

// File: testbench/tb_board_ctrl.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module tb_board_ctrl;

  localparam int TIMEOUT_CYCLES = 4000;  // About twice the run length
  localparam int PWM_WINDOW     = 16 * `BOARD_PWM_PRESCALE;

  logic                  clk = 1'b0;
  logic                  cpu_resetn;
  logic                  clk_locked_i;
  logic                  ndm_reset_i;
  board_pkg::pwm_level_t fan_level_i;
  logic                  sys_rstn_o;
  logic                  core_rstn_o;
  logic                  rtc_o;
  logic                  fan_pwm_o;

  int          value_errs = 0;
  int          other_errs = 0;
  int          cycle_cnt  = 0;
  int          rel_cycles = 0;  // Edges since cpu_resetn release
  int          clr_cycles = 0;  // Edges with the core reset sources clear
  logic        rtc_prev   = 1'b0;
  logic [63:0] fan_hist   = '0;  // Last 64 samples of the fan output
  logic        duty_chk;
  int          duty_high_exp;
  logic [31:0] lfsr_state;

  board_ctrl_top dut0 (
    .clk          ( clk          ),
    .cpu_resetn   ( cpu_resetn   ),
    .clk_locked_i ( clk_locked_i ),
    .ndm_reset_i  ( ndm_reset_i  ),
    .fan_level_i  ( fan_level_i  ),
    .sys_rstn_o   ( sys_rstn_o   ),
    .core_rstn_o  ( core_rstn_o  ),
    .rtc_o        ( rtc_o        ),
    .fan_pwm_o    ( fan_pwm_o    )
  );

  always #2 clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end else begin
      return s >> 1;
    end
  endfunction

  // One LFSR step per bit
  task automatic draw_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_sys_release();
    while (!sys_rstn_o) step_cycle();
  endtask

  task automatic wait_core_release();
    while (!core_rstn_o) step_cycle();
  endtask

  task automatic report_mismatch(input string sig, input int expected, input int actual);
    value_errs++;
    $display("[ERROR] %0t: %s expected %0d, got %0d", $time, sig, expected, actual);
  endtask

  task automatic print_summary();
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
  endtask

  // ----------------------------------------
  // Reference counters
  // ----------------------------------------

  always @(posedge clk or negedge cpu_resetn) begin
    if (!cpu_resetn) begin
      rel_cycles <= 0;
    end else begin
      rel_cycles <= rel_cycles + 1;
    end
  end

  always @(posedge clk) begin
    if (!sys_rstn_o || ndm_reset_i) begin
      clr_cycles <= 0;
    end else if (clr_cycles < 8) begin
      clr_cycles <= clr_cycles + 1;
    end
    rtc_prev <= rtc_o;
    fan_hist <= {fan_hist[62:0], fan_pwm_o};
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      other_errs++;
      $display("Run stopped after %0d cycles, stimulus never finished", cycle_cnt);
      print_summary();
      $display("Something failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  a_lock_gate: assert property (@(posedge clk)
    cpu_resetn && !$past(clk_locked_i) && !$past(sys_rstn_o) |-> !sys_rstn_o)
    else report_mismatch("sys_rstn_o", 0, $sampled(sys_rstn_o));

  a_lock_release: assert property (@(posedge clk)
    cpu_resetn && rel_cycles >= 66 && $past(clk_locked_i) |-> sys_rstn_o)
    else report_mismatch("sys_rstn_o", 1, $sampled(sys_rstn_o));

  a_sys_sticky: assert property (@(posedge clk)
    cpu_resetn && $past(sys_rstn_o) |-> sys_rstn_o)
    else report_mismatch("sys_rstn_o", 1, $sampled(sys_rstn_o));

  // 64 count cycles plus the done flag
  a_por_hold: assert property (@(posedge clk)
    cpu_resetn && rel_cycles < 65 |-> !sys_rstn_o)
    else report_mismatch("sys_rstn_o", 0, $sampled(sys_rstn_o));

  a_ndm_fall: assert property (@(posedge clk) ndm_reset_i |-> !core_rstn_o)
    else report_mismatch("core_rstn_o", 0, $sampled(core_rstn_o));

  a_core_hold: assert property (@(posedge clk) clr_cycles < 2 |-> !core_rstn_o)
    else report_mismatch("core_rstn_o", 0, $sampled(core_rstn_o));

  a_core_release: assert property (@(posedge clk)
    sys_rstn_o && !ndm_reset_i && clr_cycles >= 2 |-> core_rstn_o)
    else report_mismatch("core_rstn_o", 1, $sampled(core_rstn_o));

  a_rtc_quiet: assert property (@(posedge clk) !core_rstn_o |-> !rtc_o)
    else report_mismatch("rtc_o", 0, $sampled(rtc_o));

  a_fan_quiet: assert property (@(posedge clk) !core_rstn_o |-> !fan_pwm_o)
    else report_mismatch("fan_pwm_o", 0, $sampled(fan_pwm_o));

  a_rtc_toggle: assert property (@(posedge clk)
    core_rstn_o && $past(core_rstn_o) |-> rtc_o != rtc_prev)
    else report_mismatch("rtc_o", !$sampled(rtc_prev), $sampled(rtc_o));

  a_fan_duty: assert property (@(posedge clk)
    duty_chk |-> $countones(fan_hist) == duty_high_exp)
    else report_mismatch("fan_pwm_o high cycles", $sampled(duty_high_exp),
                         $countones($sampled(fan_hist)));

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    logic [31:0] r;
    int          i;
    cpu_resetn    = 1'b0;
    clk_locked_i  = 1'b0;
    ndm_reset_i   = 1'b0;
    fan_level_i   = '0;
    duty_chk      = 1'b0;
    duty_high_exp = 0;
    lfsr_state    = 32'hbdd1;

    // Late lock, then lock lost after release
    repeat (3) step_cycle();
    cpu_resetn = 1'b1;
    repeat (100) step_cycle();
    clk_locked_i = 1'b1;
    wait_sys_release();
    repeat (5) step_cycle();
    clk_locked_i = 1'b0;
    repeat (10) step_cycle();

    // Second board reset with lock present throughout
    cpu_resetn   = 1'b0;
    clk_locked_i = 1'b1;
    repeat (3) step_cycle();
    cpu_resetn = 1'b1;
    wait_sys_release();
    wait_core_release();
    repeat (4) step_cycle();

    // Debug reset pulses of random length, hitting a running fan
    fan_level_i = '1;
    for (i = 0; i < 4; i++) begin
      draw_bits(3, r);
      while (!(fan_pwm_o && rtc_o)) step_cycle();  // Both outputs high first
      ndm_reset_i = 1'b1;
      repeat (r + 1) step_cycle();
      ndm_reset_i = 1'b0;
      wait_core_release();
      repeat (6) step_cycle();
    end

    // Fan levels, window lands in the second period
    for (i = 0; i < 12; i++) begin
      if (i == 0) begin
        r = 0;
      end else if (i == 1) begin
        r = 15;
      end else begin
        draw_bits(`BOARD_PWM_W, r);
      end
      fan_level_i   = board_pkg::pwm_level_t'(r);
      duty_high_exp = r * `BOARD_PWM_PRESCALE;
      repeat (2 * PWM_WINDOW + 3) step_cycle();
      duty_chk = 1'b1;
      step_cycle();
      duty_chk = 1'b0;
    end

    repeat (4) step_cycle();
    print_summary();
    if (value_errs == 0 && other_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: rtl/board_ctrl_top.sv
`timescale 1ns/1ps

module board_ctrl_top (
  input  logic                  clk,
  input  logic                  cpu_resetn,
  input  logic                  clk_locked_i,
  input  logic                  ndm_reset_i,
  input  board_pkg::pwm_level_t fan_level_i,
  output logic                  sys_rstn_o,
  output logic                  core_rstn_o,
  output logic                  rtc_o,
  output logic                  fan_pwm_o
);

  board_pkg::rst_bus_t  rst_bus;
  board_pkg::time_bus_t time_bus;

  // ----------------------------------------
  // Reset sequencing
  // ----------------------------------------

  reset_ctrl i_reset_ctrl (
    .clk          ( clk          ),
    .cpu_resetn   ( cpu_resetn   ),
    .clk_locked_i ( clk_locked_i ),
    .ndm_reset_i  ( ndm_reset_i  ),
    .rst_bus_o    ( rst_bus      )
  );

  assign sys_rstn_o  = rst_bus.por_rstn;
  assign core_rstn_o = rst_bus.core_rstn;

  // ----------------------------------------
  // Time references
  // ----------------------------------------

  timebase i_timebase (
    .clk         ( clk               ),
    .core_rstn_i ( rst_bus.core_rstn ),  // Held with the core
    .time_bus_o  ( time_bus          )
  );

  assign rtc_o = time_bus.rtc;

  // ----------------------------------------
  // Fan
  // ----------------------------------------

  fan_pwm i_fan_pwm (
    .clk         ( clk               ),
    .core_rstn_i ( rst_bus.core_rstn ),
    .pwm_tick_i  ( time_bus.pwm_tick ),
    .fan_level_i ( fan_level_i       ),
    .fan_pwm_o   ( fan_pwm_o         )
  );

endmodule

// File: rtl/fan_pwm.sv
`timescale 1ns/1ps

module fan_pwm (
  input  logic                  clk,
  input  logic                  core_rstn_i,
  input  logic                  pwm_tick_i,
  input  board_pkg::pwm_level_t fan_level_i,
  output logic                  fan_pwm_o
);

  board_pkg::pwm_level_t cnt_q;
  board_pkg::pwm_level_t level_q;    // Duty for the running period
  board_pkg::pwm_level_t cnt_nxt;
  board_pkg::pwm_level_t level_nxt;
  logic                  out_q;

  // ----------------------------------------
  // Next period position and duty
  // ----------------------------------------

  assign cnt_nxt = cnt_q + 1'b1;

  // New level only taken as the counter wraps to zero
  always_comb begin
    level_nxt = level_q;
    if (&cnt_q) begin
      level_nxt = fan_level_i;
    end
  end

  // ----------------------------------------
  // Tick driven state
  // ----------------------------------------

  always_ff @(posedge clk or negedge core_rstn_i) begin
    if (!core_rstn_i) begin
      cnt_q   <= '0;
      level_q <= '0;
      out_q   <= 1'b0;
    end else if (pwm_tick_i) begin
      cnt_q   <= cnt_nxt;
      level_q <= level_nxt;
      out_q   <= (cnt_nxt < level_nxt);  // High for the first level ticks
    end
  end

  assign fan_pwm_o = out_q;

  // Zero duty keeps the fan off for the whole period
  a_zero_level_off: assert property (
    @(posedge clk) disable iff (!core_rstn_i)
    (level_q == '0) |-> !fan_pwm_o
  );

endmodule

// File: rtl/timebase.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module timebase (
  input  logic                 clk,
  input  logic                 core_rstn_i,
  output board_pkg::time_bus_t time_bus_o
);

  localparam int unsigned PRESC_W =
    (`BOARD_PWM_PRESCALE > 1) ? $clog2(`BOARD_PWM_PRESCALE) : 1;
  localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(`BOARD_PWM_PRESCALE - 1);

  logic               rtc_q;
  logic               tick_q;
  logic [PRESC_W-1:0] presc_q;

  // ----------------------------------------
  // RTC divider and PWM prescaler
  // ----------------------------------------

  always_ff @(posedge clk or negedge core_rstn_i) begin
    if (!core_rstn_i) begin
      rtc_q   <= 1'b0;
      presc_q <= '0;
      tick_q  <= 1'b0;
    end else begin
      rtc_q <= ~rtc_q;  // Half the system clock
      if (presc_q == PRESC_LAST) begin
        presc_q <= '0;
      end else begin
        presc_q <= presc_q + 1'b1;
      end
      tick_q <= (presc_q == PRESC_LAST);  // One cycle per wrap
    end
  end

  assign time_bus_o.rtc      = rtc_q;
  assign time_bus_o.pwm_tick = tick_q;

  // Strobe never stretches into a level
  a_tick_single: assert property (
    @(posedge clk) disable iff (!core_rstn_i)
    tick_q |=> !tick_q
  );

endmodule

// File: rtl/reset_ctrl.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module reset_ctrl (
  input  logic                clk,
  input  logic                cpu_resetn,
  input  logic                clk_locked_i,
  input  logic                ndm_reset_i,
  output board_pkg::rst_bus_t rst_bus_o
);

  localparam int unsigned CNT_W  = `BOARD_POR_COUNT_W;
  localparam int unsigned STAGES = `BOARD_SYNC_STAGES;

  logic [CNT_W-1:0]  por_cnt_q;
  logic              por_done_q;
  logic              por_rstn_q;
  logic              core_src_n;   // Low while core must be held
  logic [STAGES-1:0] core_sync_q;

  // ----------------------------------------
  // Power-on reset counter
  // ----------------------------------------

  always_ff @(posedge clk or negedge cpu_resetn) begin
    if (!cpu_resetn) begin
      por_cnt_q  <= '0;
      por_done_q <= 1'b0;
    end else begin
      if (!(&por_cnt_q)) begin
        por_cnt_q <= por_cnt_q + 1'b1;  // Stops at all ones
      end
      por_done_q <= por_done_q | (&por_cnt_q);
    end
  end

  // Release needs the count and clock lock together,
  // then stays released until the board reset returns
  always_ff @(posedge clk or negedge cpu_resetn) begin
    if (!cpu_resetn) begin
      por_rstn_q <= 1'b0;
    end else if (por_done_q && clk_locked_i) begin
      por_rstn_q <= 1'b1;
    end
  end

  // ----------------------------------------
  // Core reset synchronizer
  // ----------------------------------------

  assign core_src_n = por_rstn_q & ~ndm_reset_i;

  // Asserts at once, releases after STAGES rising edges
  always_ff @(posedge clk or negedge core_src_n) begin
    if (!core_src_n) begin
      core_sync_q <= '0;
    end else begin
      core_sync_q <= {core_sync_q[STAGES-2:0], 1'b1};
    end
  end

  assign rst_bus_o.por_rstn  = por_rstn_q;
  assign rst_bus_o.core_rstn = core_sync_q[STAGES-1];

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Power-on release only follows a cycle with lock present
  a_por_needs_lock: assert property (
    @(posedge clk) disable iff (!cpu_resetn)
    $rose(por_rstn_q) |-> $past(clk_locked_i)
  );

  // Debug reset request reaches the core reset through the chain
  a_ndm_holds_core: assert property (
    @(posedge clk)
    ndm_reset_i |-> !rst_bus_o.core_rstn
  );

endmodule

// File: rtl/board_pkg.sv
`include "board_cfg.svh"

package board_pkg;

  // ----------------------------------------
  // Reset levels out of reset_ctrl
  // ----------------------------------------
  typedef struct packed {
    logic por_rstn;   // Board power-on reset, sticky once released
    logic core_rstn;  // Power-on reset merged with debug reset
  } rst_bus_t;

  // ----------------------------------------
  // Time references out of timebase
  // ----------------------------------------
  typedef struct packed {
    logic rtc;       // clk divided by two
    logic pwm_tick;  // One-cycle strobe per prescale period
  } time_bus_t;

  // Fan duty, also the width of the PWM period counter
  typedef logic [`BOARD_PWM_W-1:0] pwm_level_t;

endpackage

// File: rtl/board_cfg.svh
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// ----------------------------------------
// Reset sequencing
// ----------------------------------------

// Power-on counter width, reset held for 2**W cycles
`define BOARD_POR_COUNT_W 6

// Flops in the core reset synchronizer
`define BOARD_SYNC_STAGES 2

// ----------------------------------------
// Fan PWM
// ----------------------------------------

`define BOARD_PWM_W 4         // Level and period counter width
`define BOARD_PWM_PRESCALE 4  // clk cycles per PWM tick

`endif
